// File: design/lsu_pkg.sv
/* LSU subsystem types */
package lsu_pkg;

  // Widths with a meaning
  typedef logic [31:0] xlen_t;
  typedef logic [31:0] cb_addr_t;
  typedef logic [31:0] pc_t;
  typedef logic [3:0]  cb_strb_t;

  typedef enum logic [2:0] {
    B  = 3'd0,
    H  = 3'd1,
    W  = 3'd2,
    BU = 3'd3,
    HU = 3'd4
  } lsu_w_t;

  // NO_LSU must stay zero, registers clear to it
  typedef enum logic [1:0] {
    NO_LSU    = 2'd0,
    LSU_LOAD  = 2'd1,
    LSU_STORE = 2'd2
  } lsu_op_typ_t;

  typedef enum logic [1:0] {
    CB_OKAY   = 2'b00,
    CB_SLVERR = 2'b10
  } cb_resp_t;

  typedef struct packed {
    lsu_op_typ_t op_typ;
    lsu_w_t      width;
    cb_addr_t    addr;
    xlen_t       wdata;
    pc_t         pc_addr;
  } s_lsu_op_t;

  // Master to slave
  typedef struct packed {
    cb_addr_t rd_addr;
    logic     rd_addr_valid;
    logic     rd_ready;
    cb_addr_t wr_addr;
    logic     wr_addr_valid;
    xlen_t    wr_data;
    cb_strb_t wr_strobe;
    logic     wr_data_valid;
    logic     wr_resp_ready;
  } s_cb_mosi_t;

  // Slave to master
  typedef struct packed {
    logic     rd_addr_ready;
    xlen_t    rd_data;
    logic     rd_valid;
    cb_resp_t rd_resp;
    logic     wr_addr_ready;
    logic     wr_data_ready;
    logic     wr_resp_valid;
    cb_resp_t wr_resp_error;
  } s_cb_miso_t;

  typedef struct packed {
    logic     active;
    cb_addr_t mtval;
  } s_trap_info_t;

endpackage

// File: design/lsu.sv
/* Load/store unit */
`timescale 1ns/10ps

module lsu #(
  parameter int SUPPORT_WR_RESP = 1
) (
  input  logic                  clk,
  input  logic                  rst_i,
  // Execute stage side
  input  lsu_pkg::s_lsu_op_t    lsu_i,
  output logic                  lsu_bp_o,
  output lsu_pkg::s_lsu_op_t    wb_lsu_o,
  // Core data bus
  output lsu_pkg::s_cb_mosi_t   data_cb_mosi_o,
  input  lsu_pkg::s_cb_miso_t   data_cb_miso_i,
  // Access faults
  output lsu_pkg::s_trap_info_t trap_ld_o,
  output lsu_pkg::s_trap_info_t trap_st_o
);
  import lsu_pkg::*;

  s_lsu_op_t lsu_ff, lsu_d;
  logic      dp_done_ff, dp_done_d;
  logic      lock_ff, lock_d;
  cb_addr_t  locked_addr_ff;
  cb_addr_t  req_addr;
  cb_strb_t  st_strb;

  logic ap_rd, ap_wr;
  logic dp_rd, dp_wr;
  logic bp_addr, bp_data;

  // Byte lanes touched by an access
  function automatic cb_strb_t mask_strobe(lsu_w_t size, logic [1:0] offset);
    cb_strb_t mask;
    case (size)
      B, BU:   mask = 4'b0001;
      H, HU:   mask = 4'b0011;
      default: mask = 4'b1111;
    endcase
    return cb_strb_t'(mask << offset);
  endfunction

  // Move store data onto its lanes with idle lanes zeroed
  function automatic xlen_t lane_data(xlen_t wdata, cb_strb_t strb, logic [1:0] offset);
    xlen_t shifted;
    shifted = wdata << {offset, 3'b000};
    for (int i = 0; i < 4; i++) begin
      if (!strb[i]) begin
        shifted[i*8 +: 8] = 8'h00;
      end
    end
    return shifted;
  endfunction

  always_comb begin
    ap_rd = (lsu_i.op_typ == LSU_LOAD);
    ap_wr = (lsu_i.op_typ == LSU_STORE);
    dp_rd = (lsu_ff.op_typ == LSU_LOAD);
    dp_wr = (lsu_ff.op_typ == LSU_STORE);

    data_cb_mosi_o               = s_cb_mosi_t'('0);
    data_cb_mosi_o.rd_ready      = 1'b1;
    data_cb_mosi_o.wr_resp_ready = 1'b1;

    // Data phase of the registered op goes first
    st_strb = mask_strobe(lsu_ff.width, lsu_ff.addr[1:0]);
    bp_data = 1'b0;
    if (!dp_done_ff) begin
      if (dp_rd) begin
        bp_data = !data_cb_miso_i.rd_valid;
      end else if (dp_wr) begin
        bp_data = !data_cb_miso_i.wr_data_ready;
        data_cb_mosi_o.wr_strobe     = st_strb;
        data_cb_mosi_o.wr_data       = lane_data(lsu_ff.wdata, st_strb, lsu_ff.addr[1:0]);
        data_cb_mosi_o.wr_data_valid = 1'b1;
      end
    end

    // Address phase only without data back-pressure
    req_addr = lock_ff ? locked_addr_ff : lsu_i.addr;
    bp_addr  = 1'b0;
    if (ap_rd) begin
      data_cb_mosi_o.rd_addr       = {req_addr[31:2], 2'b00};
      data_cb_mosi_o.rd_addr_valid = !bp_data;
      bp_addr                      = !data_cb_miso_i.rd_addr_ready;
    end else if (ap_wr) begin
      data_cb_mosi_o.wr_addr       = {req_addr[31:2], 2'b00};
      data_cb_mosi_o.wr_addr_valid = !bp_data;
      bp_addr                      = !data_cb_miso_i.wr_addr_ready;
    end

    lsu_bp_o = bp_addr || bp_data;

    // Keep the address of an issued request that is not taken
    lock_d = (data_cb_mosi_o.rd_addr_valid && !data_cb_miso_i.rd_addr_ready) ||
             (data_cb_mosi_o.wr_addr_valid && !data_cb_miso_i.wr_addr_ready);

    lsu_d     = lsu_ff;
    dp_done_d = !bp_data;
    if (!lsu_bp_o) begin
      lsu_d      = lsu_i;
      lsu_d.addr = req_addr;
      dp_done_d  = 1'b0;
    end
  end

  assign wb_lsu_o = lsu_ff;

  always_comb begin
    trap_ld_o = s_trap_info_t'('0);
    trap_st_o = s_trap_info_t'('0);
    if (data_cb_miso_i.rd_valid && (data_cb_miso_i.rd_resp != CB_OKAY)) begin
      trap_ld_o.active = 1'b1;
      trap_ld_o.mtval  = {lsu_ff.addr[31:2], 2'b00};
    end
    if ((SUPPORT_WR_RESP == 1) && data_cb_miso_i.wr_resp_valid &&
        (data_cb_miso_i.wr_resp_error != CB_OKAY)) begin
      trap_st_o.active = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      lsu_ff     <= s_lsu_op_t'('0);
      dp_done_ff <= 1'b0;
      lock_ff    <= 1'b0;
    end else begin
      lsu_ff     <= lsu_d;
      dp_done_ff <= dp_done_d;
      lock_ff    <= lock_d;
    end
  end

  always_ff @(posedge clk) begin
    if (!lock_ff) begin
      locked_addr_ff <= lsu_i.addr;
    end
  end

  // Pending address held steady until the slave takes it
  a_rd_addr_stable: assert property (@(posedge clk) disable iff (rst_i)
    data_cb_mosi_o.rd_addr_valid && !data_cb_miso_i.rd_addr_ready
    |=> data_cb_mosi_o.rd_addr_valid && $stable(data_cb_mosi_o.rd_addr));

  a_wr_addr_stable: assert property (@(posedge clk) disable iff (rst_i)
    data_cb_mosi_o.wr_addr_valid && !data_cb_miso_i.wr_addr_ready
    |=> data_cb_mosi_o.wr_addr_valid && $stable(data_cb_mosi_o.wr_addr));

  // Read data only returns for a load still in its data phase
  a_rd_for_load: assert property (@(posedge clk) disable iff (rst_i)
    data_cb_miso_i.rd_valid |-> (dp_rd && !dp_done_ff));

endmodule

// File: design/cb_data_ram.sv
/* Core data bus RAM slave */
`timescale 1ns/10ps

module cb_data_ram #(
  parameter int RAM_DEPTH_WORDS = 256
) (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                stall_i,
  input  lsu_pkg::s_cb_mosi_t data_cb_mosi_i,
  output lsu_pkg::s_cb_miso_t data_cb_miso_o
);
  import lsu_pkg::*;

  localparam int          IDX_W = $clog2(RAM_DEPTH_WORDS);
  localparam logic [29:0] DEPTH = 30'(RAM_DEPTH_WORDS);

  typedef enum logic [1:0] {
    PEND_NONE,
    PEND_RD,
    PEND_WR
  } pend_t;

  xlen_t mem [RAM_DEPTH_WORDS];

  pend_t            pend_ff;
  logic [IDX_W-1:0] pend_idx_ff;
  logic             pend_err_ff;
  logic             resp_valid_ff;
  logic             resp_err_ff;

  logic     addr_ready;
  logic     rd_addr_hs, wr_addr_hs;
  logic     rd_beat, wr_beat;
  logic     dp_done;
  cb_addr_t new_addr;

  always_comb begin
    // Data phase beats
    rd_beat = (pend_ff == PEND_RD) && !stall_i;
    wr_beat = (pend_ff == PEND_WR) && !stall_i && data_cb_mosi_i.wr_data_valid;
    dp_done = (rd_beat && data_cb_mosi_i.rd_ready) || wr_beat;

    // Next address only once the current data phase clears
    addr_ready = !stall_i && ((pend_ff == PEND_NONE) || dp_done);
    rd_addr_hs = data_cb_mosi_i.rd_addr_valid && addr_ready;
    wr_addr_hs = data_cb_mosi_i.wr_addr_valid && addr_ready;
    new_addr   = rd_addr_hs ? data_cb_mosi_i.rd_addr : data_cb_mosi_i.wr_addr;

    data_cb_miso_o               = s_cb_miso_t'('0);
    data_cb_miso_o.rd_addr_ready = addr_ready;
    data_cb_miso_o.wr_addr_ready = addr_ready;
    data_cb_miso_o.rd_valid      = rd_beat;
    data_cb_miso_o.wr_data_ready = (pend_ff == PEND_WR) && !stall_i;
    if (rd_beat) begin
      data_cb_miso_o.rd_data = pend_err_ff ? '0 : mem[pend_idx_ff];
      data_cb_miso_o.rd_resp = pend_err_ff ? CB_SLVERR : CB_OKAY;
    end
    data_cb_miso_o.wr_resp_valid = resp_valid_ff;
    data_cb_miso_o.wr_resp_error = resp_err_ff ? CB_SLVERR : CB_OKAY;
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pend_ff       <= PEND_NONE;
      resp_valid_ff <= 1'b0;
    end else begin
      resp_valid_ff <= wr_beat;
      if (rd_addr_hs) begin
        pend_ff <= PEND_RD;
      end else if (wr_addr_hs) begin
        pend_ff <= PEND_WR;
      end else if (dp_done) begin
        pend_ff <= PEND_NONE;
      end
    end
  end

  // Word index and range check of the accepted address
  always_ff @(posedge clk) begin
    if (rd_addr_hs || wr_addr_hs) begin
      pend_idx_ff <= new_addr[IDX_W+1:2];
      pend_err_ff <= (new_addr[31:2] >= DEPTH);
    end
    if (wr_beat) begin
      resp_err_ff <= pend_err_ff;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_beat && !pend_err_ff) begin
      for (int i = 0; i < 4; i++) begin
        if (data_cb_mosi_i.wr_strobe[i]) begin
          mem[pend_idx_ff][i*8 +: 8] <= data_cb_mosi_i.wr_data[i*8 +: 8];
        end
      end
    end
  end

  // Master offers write data only against an accepted write address
  a_wr_data_pending: assert property (@(posedge clk) disable iff (rst_i)
    data_cb_mosi_i.wr_data_valid |-> (pend_ff == PEND_WR));

endmodule

// File: design/load_align.sv
/* Load data alignment */
`timescale 1ns/10ps

module load_align (
  input  lsu_pkg::s_lsu_op_t wb_lsu_i,
  input  lsu_pkg::xlen_t     rd_data_i,
  input  logic               rd_valid_i,
  output logic               ld_valid_o,
  output lsu_pkg::xlen_t     ld_data_o
);
  import lsu_pkg::*;

  xlen_t shifted;

  always_comb begin
    ld_valid_o = rd_valid_i && (wb_lsu_i.op_typ == LSU_LOAD);

    // Bring the addressed lane down to bit 0
    shifted = rd_data_i >> {wb_lsu_i.addr[1:0], 3'b000};

    case (wb_lsu_i.width)
      B: begin
        ld_data_o = {{24{shifted[7]}}, shifted[7:0]};
      end
      BU: begin
        ld_data_o = {24'h0, shifted[7:0]};
      end
      H: begin
        ld_data_o = {{16{shifted[15]}}, shifted[15:0]};
      end
      HU: begin
        ld_data_o = {16'h0, shifted[15:0]};
      end
      default: begin
        // Full word
        ld_data_o = rd_data_i;
      end
    endcase
  end

endmodule

// File: design/lsu_subsys_top.sv
/* LSU subsystem top */
`timescale 1ns/10ps

module lsu_subsys_top #(
  parameter int SUPPORT_WR_RESP = 1,
  parameter int RAM_DEPTH_WORDS = 256
) (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  stall_i,
  input  lsu_pkg::s_lsu_op_t    lsu_i,
  output logic                  lsu_bp_o,
  output logic                  ld_valid_o,
  output lsu_pkg::xlen_t        ld_data_o,
  output lsu_pkg::s_trap_info_t trap_ld_o,
  output lsu_pkg::s_trap_info_t trap_st_o
);
  import lsu_pkg::*;

  s_lsu_op_t  wb_lsu;
  s_cb_mosi_t data_cb_mosi;
  s_cb_miso_t data_cb_miso;

  lsu #(
    .SUPPORT_WR_RESP (SUPPORT_WR_RESP)
  ) u_lsu (
    .clk            (clk),
    .rst_i          (rst_i),
    .lsu_i          (lsu_i),
    .lsu_bp_o       (lsu_bp_o),
    .wb_lsu_o       (wb_lsu),
    .data_cb_mosi_o (data_cb_mosi),
    .data_cb_miso_i (data_cb_miso),
    .trap_ld_o      (trap_ld_o),
    .trap_st_o      (trap_st_o)
  );

  cb_data_ram #(
    .RAM_DEPTH_WORDS (RAM_DEPTH_WORDS)
  ) u_ram (
    .clk            (clk),
    .rst_i          (rst_i),
    .stall_i        (stall_i),
    .data_cb_mosi_i (data_cb_mosi),
    .data_cb_miso_o (data_cb_miso)
  );

  // Write-back side of the load path
  load_align u_load_align (
    .wb_lsu_i   (wb_lsu),
    .rd_data_i  (data_cb_miso.rd_data),
    .rd_valid_i (data_cb_miso.rd_valid),
    .ld_valid_o (ld_valid_o),
    .ld_data_o  (ld_data_o)
  );

endmodule

// File: dv/lsu_tb.sv
/* LSU subsystem testbench */
`timescale 1ns/10ps

module lsu_tb;
  import lsu_pkg::*;

  localparam int       RAM_DEPTH_WORDS = 256;
  localparam cb_addr_t RAM_BYTES       = 32'(RAM_DEPTH_WORDS * 4);

  typedef struct packed {
    lsu_op_typ_t op;
    lsu_w_t      width;
    cb_addr_t    addr;
    xlen_t       wdata;
    xlen_t       exp_data;
    logic        quiet;
  } stim_t;

  typedef struct packed {
    xlen_t    data;
    logic     trap;
    cb_addr_t mtval;
  } exp_load_t;

  logic         clk;
  logic         rst_i;
  logic         stall_i;
  s_lsu_op_t    lsu_i;
  logic         lsu_bp_o;
  logic         ld_valid_o;
  xlen_t        ld_data_o;
  s_trap_info_t trap_ld_o;
  s_trap_info_t trap_st_o;

  stim_t      stim [$];
  exp_load_t  exp_q [$];
  logic [7:0] ref_mem [RAM_DEPTH_WORDS*4];
  integer     seed;
  int         cycles = 0;
  int         cycle_limit;
  int         value_errs;
  int         other_errs;
  int         st_traps_exp;
  int         st_traps_seen;
  logic       load_prev;

  lsu_subsys_top #(
    .SUPPORT_WR_RESP (1),
    .RAM_DEPTH_WORDS (RAM_DEPTH_WORDS)
  ) UUT (
    .clk        (clk),
    .rst_i      (rst_i),
    .stall_i    (stall_i),
    .lsu_i      (lsu_i),
    .lsu_bp_o   (lsu_bp_o),
    .ld_valid_o (ld_valid_o),
    .ld_data_o  (ld_data_o),
    .trap_ld_o  (trap_ld_o),
    .trap_st_o  (trap_st_o)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      value_errs++;
    end
  endtask

  function automatic void add_entry(lsu_op_typ_t op, lsu_w_t width, cb_addr_t addr,
                                    xlen_t wdata, xlen_t exp_data, logic quiet);
    stim.push_back('{op, width, addr, wdata, exp_data, quiet});
  endfunction

  // Load result built byte by byte from the model
  function automatic xlen_t ref_load(lsu_w_t width, cb_addr_t addr);
    logic [9:0] a;
    logic [7:0] b0, b1, b2, b3;
    xlen_t      r;
    a = (width == W) ? {addr[9:2], 2'b00} : addr[9:0];
    b0 = ref_mem[a];
    b1 = ref_mem[a + 10'd1];
    b2 = ref_mem[a + 10'd2];
    b3 = ref_mem[a + 10'd3];
    case (width)
      B:       r = {{24{b0[7]}}, b0};
      BU:      r = {24'h0, b0};
      H:       r = {{16{b1[7]}}, b1, b0};
      HU:      r = {16'h0, b1, b0};
      default: r = {b3, b2, b1, b0};
    endcase
    return r;
  endfunction

  task automatic ref_store(input lsu_w_t width, input cb_addr_t addr, input xlen_t wdata);
    logic [9:0] a;
    xlen_t      wd;
    int         nbytes;
    a  = addr[9:0];
    wd = wdata;
    case (width)
      B, BU:   nbytes = 1;
      H, HU:   nbytes = 2;
      default: nbytes = 4;
    endcase
    for (int k = 0; k < nbytes; k++) begin
      ref_mem[a] = wd[7:0];
      a  = a + 10'd1;
      wd = wd >> 8;
    end
  endtask

  // Expected results are fixed when the op is accepted
  task automatic accept_op(input stim_t cur);
    exp_load_t e;
    e.trap  = (cur.addr >= RAM_BYTES);
    e.mtval = {cur.addr[31:2], 2'b00};
    e.data  = e.trap ? 32'h0 : ref_load(cur.width, cur.addr);
    if (cur.op == LSU_LOAD) begin
      check_val("exp table", e.data, cur.exp_data);
      exp_q.push_back(e);
      load_prev = 1'b1;
    end else if (cur.op == LSU_STORE) begin
      if (e.trap) begin
        st_traps_exp++;
      end else begin
        ref_store(cur.width, cur.addr, cur.wdata);
      end
    end
  endtask

  task automatic observe_outputs();
    exp_load_t e;
    if (ld_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("Load result at t=%0t with no load outstanding", $time);
        other_errs++;
      end else begin
        e = exp_q.pop_front();
        check_val("ld_data_o", ld_data_o, e.data);
        check_val("trap_ld_o.active", 32'(trap_ld_o.active), 32'(e.trap));
        if (e.trap) begin
          check_val("trap_ld_o.mtval", trap_ld_o.mtval, e.mtval);
        end
      end
    end else begin
      check_val("trap_ld_o.active", 32'(trap_ld_o.active), 32'd0);
    end
    // Unstalled cycle right after a load acceptance must deliver it
    if (load_prev && !stall_i) begin
      check_val("ld_valid_o", 32'(ld_valid_o), 32'd1);
    end
    if (trap_st_o.active) begin
      st_traps_seen++;
    end
  endtask

  task automatic drive_cycle(input stim_t cur, input pc_t pc);
    @(posedge clk);
    #1;
    lsu_i.op_typ  = cur.op;
    lsu_i.width   = cur.width;
    lsu_i.addr    = cur.addr;
    lsu_i.wdata   = cur.wdata;
    lsu_i.pc_addr = pc;
    stall_i       = cur.quiet ? 1'b0 : (($random(seed) & 32'd3) == 32'd0);
    @(negedge clk);
    observe_outputs();
    load_prev = 1'b0;
  endtask

  task automatic build_table();
    // Word stores then word loads
    add_entry(LSU_STORE, W,  32'h0000_0000, 32'h1122_3344, 32'h0, 1'b0);
    add_entry(LSU_STORE, W,  32'h0000_0004, 32'h8899_aabb, 32'h0, 1'b0);
    add_entry(LSU_STORE, W,  32'h0000_03fc, 32'hdead_beef, 32'h0, 1'b0);
    add_entry(LSU_LOAD,  W,  32'h0000_0000, 32'h0, 32'h1122_3344, 1'b0);
    add_entry(LSU_LOAD,  W,  32'h0000_0004, 32'h0, 32'h8899_aabb, 1'b0);
    add_entry(LSU_LOAD,  W,  32'h0000_03fc, 32'h0, 32'hdead_beef, 1'b0);
    // Byte lanes 1 to 3 of one word
    add_entry(LSU_STORE, W,  32'h0000_0010, 32'h0123_4567, 32'h0, 1'b0);
    add_entry(LSU_STORE, B,  32'h0000_0011, 32'h0000_00a5, 32'h0, 1'b0);
    add_entry(LSU_STORE, B,  32'h0000_0012, 32'h1234_56f0, 32'h0, 1'b0);
    add_entry(LSU_STORE, BU, 32'h0000_0013, 32'h0000_0080, 32'h0, 1'b0);
    add_entry(LSU_LOAD,  W,  32'h0000_0010, 32'h0, 32'h80f0_a567, 1'b0);
    add_entry(LSU_LOAD,  B,  32'h0000_0011, 32'h0, 32'hffff_ffa5, 1'b0);
    add_entry(LSU_LOAD,  BU, 32'h0000_0011, 32'h0, 32'h0000_00a5, 1'b0);
    add_entry(LSU_LOAD,  B,  32'h0000_0012, 32'h0, 32'hffff_fff0, 1'b0);
    add_entry(LSU_LOAD,  BU, 32'h0000_0013, 32'h0, 32'h0000_0080, 1'b0);
    // Halfword on top, bytes 0 and 1 below
    add_entry(LSU_STORE, H,  32'h0000_0016, 32'habcd_8001, 32'h0, 1'b0);
    add_entry(LSU_STORE, B,  32'h0000_0014, 32'h0000_007e, 32'h0, 1'b0);
    add_entry(LSU_STORE, B,  32'h0000_0015, 32'h0000_0099, 32'h0, 1'b0);
    add_entry(LSU_LOAD,  H,  32'h0000_0014, 32'h0, 32'hffff_997e, 1'b0);
    add_entry(LSU_LOAD,  HU, 32'h0000_0016, 32'h0, 32'h0000_8001, 1'b0);
    add_entry(LSU_LOAD,  H,  32'h0000_0016, 32'h0, 32'hffff_8001, 1'b0);
    add_entry(LSU_LOAD,  W,  32'h0000_0014, 32'h0, 32'h8001_997e, 1'b0);
    // Low halfword over a full word
    add_entry(LSU_STORE, W,  32'h0000_0018, 32'h7766_5544, 32'h0, 1'b0);
    add_entry(LSU_STORE, H,  32'h0000_0018, 32'h5a5a_c3d2, 32'h0, 1'b0);
    add_entry(LSU_LOAD,  W,  32'h0000_0018, 32'h0, 32'h7766_c3d2, 1'b0);
    add_entry(LSU_LOAD,  B,  32'h0000_0018, 32'h0, 32'hffff_ffd2, 1'b0);
    add_entry(LSU_LOAD,  BU, 32'h0000_001a, 32'h0, 32'h0000_0066, 1'b0);
    // Beyond the RAM where the index aliases word 0
    add_entry(LSU_STORE, W,  32'h0000_0400, 32'hcafe_f00d, 32'h0, 1'b0);
    add_entry(LSU_LOAD,  W,  32'h0000_0400, 32'h0, 32'h0, 1'b0);
    add_entry(LSU_LOAD,  BU, 32'h0000_07ff, 32'h0, 32'h0, 1'b0);
    add_entry(LSU_LOAD,  W,  32'h0000_0000, 32'h0, 32'h1122_3344, 1'b0);
    // Back to back with no stalls
    add_entry(LSU_LOAD,  W,  32'h0000_0004, 32'h0, 32'h8899_aabb, 1'b1);
    add_entry(LSU_LOAD,  W,  32'h0000_03fc, 32'h0, 32'hdead_beef, 1'b1);
    add_entry(LSU_LOAD,  H,  32'h0000_0016, 32'h0, 32'hffff_8001, 1'b1);
    add_entry(NO_LSU,    W,  32'h0000_0000, 32'h0, 32'h0, 1'b1);
    add_entry(LSU_STORE, W,  32'h0000_0008, 32'h0bad_cafe, 32'h0, 1'b1);
    add_entry(LSU_LOAD,  W,  32'h0000_0008, 32'h0, 32'h0bad_cafe, 1'b1);
    add_entry(LSU_LOAD,  BU, 32'h0000_000b, 32'h0, 32'h0000_000b, 1'b1);
  endtask

  initial begin
    int    idx;
    int    settle;
    stim_t idle;
    seed          = 32'h42f1_e2b7;
    value_errs    = 0;
    other_errs    = 0;
    st_traps_exp  = 0;
    st_traps_seen = 0;
    load_prev     = 1'b0;
    rst_i         = 1'b1;
    stall_i       = 1'b0;
    lsu_i         = '0;
    build_table();
    cycle_limit = stim.size() * 40 + 100;

    repeat (5) @(posedge clk);
    #1;
    rst_i = 1'b0;
    @(negedge clk);
    check_val("ld_valid_o", 32'(ld_valid_o), 32'd0);
    check_val("lsu_bp_o", 32'(lsu_bp_o), 32'd0);
    check_val("trap_ld_o.active", 32'(trap_ld_o.active), 32'd0);
    check_val("trap_st_o.active", 32'(trap_st_o.active), 32'd0);

    // Hold each entry until it is taken
    idx = 0;
    while (idx < stim.size()) begin
      drive_cycle(stim[idx], 32'h0000_1000 + 32'(idx * 4));
      if (!lsu_bp_o) begin
        accept_op(stim[idx]);
        idx++;
      end
    end

    idle       = '0;
    idle.quiet = 1'b1;
    settle     = 0;
    while ((exp_q.size() != 0) || (settle < 4)) begin
      drive_cycle(idle, 32'h0);
      settle++;
    end
    check_val("trap_st_o pulses", 32'(st_traps_seen), 32'(st_traps_exp));

    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if ((value_errs + other_errs) == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: files.f
design/lsu_pkg.sv
design/lsu.sv
design/cb_data_ram.sv
design/load_align.sv
design/lsu_subsys_top.sv
dv/lsu_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/10ps
TOP      = lsu_tb
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
